//--- rtl/lab_pkg.sv
`default_nettype none

package lab_pkg;

    //////////////////////////////
    // Widths and rates
    //////////////////////////////

    // Free-running timer
    localparam int TIMER_W    = 32;
    // Scan moves every 2**SCAN_SHIFT cycles
    localparam int SCAN_SHIFT = 4;
    localparam int SEL_W      = 5;
    localparam int DIGIT_W    = 4;
    localparam int RESULT_W   = 8;
    // Active display digits, rest stay dark
    localparam int NUM_SCAN   = 3;
    localparam int AN_W       = 8;
    localparam int SEG_W      = 7;

    // Top count of a decimal digit
    localparam logic [DIGIT_W-1:0] DIGIT_MAX = 4'd9;

    //////////////////////////////
    // Types
    //////////////////////////////

    // Encoding matches sw[6:5]
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_MUL = 2'd2,
        ALU_CAT = 2'd3
    } alu_op_e;

    // Value doubles as the anode index
    typedef enum logic [1:0] {
        SCAN_LOW  = 2'd0,
        SCAN_HIGH = 2'd1,
        SCAN_OP   = 2'd2
    } scan_state_e;

    // Same bit order as the switch bus, sw[8] first
    typedef struct packed {
        logic             dir_tens;
        logic             dir_ones;
        alu_op_e          op;
        logic [SEL_W-1:0] rate_sel;
    } ctrl_t;

    localparam int SW_W = $bits(ctrl_t);

    typedef struct packed {
        logic [DIGIT_W-1:0] tens;
        logic [DIGIT_W-1:0] ones;
    } digits_t;

    //////////////////////////////
    // Segment glyphs, active low, bit 6 is g
    //////////////////////////////

    localparam logic [SEG_W-1:0] HEX_GLYPH [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    // A, S, M, C in opcode order
    localparam logic [SEG_W-1:0] OP_GLYPH [4] = '{7'h08, 7'h12, 7'h48, 7'h46};

endpackage

`default_nettype wire

//--- rtl/rate_timer.sv
`timescale 1ns/1ns
`default_nettype none

module rate_timer import lab_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [SEL_W-1:0] rate_sel,
    output logic             step,
    output logic             scan_step
);

    // Free-running count
    logic [TIMER_W-1:0] count;
    // Low rate_sel bits set
    logic [TIMER_W-1:0] step_mask;
    logic               step_hit;
    logic               scan_hit;

    //////////////////////////////
    // Counter
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            // Wraps after 2**32 cycles
            count <= count + 1'b1;
        end
    end

    //////////////////////////////
    // Rate compares
    //////////////////////////////

    // rate_sel 0 gives an empty mask, so a hit every cycle
    assign step_mask = ~({TIMER_W{1'b1}} << rate_sel);
    assign step_hit  = ((count & step_mask) == step_mask);

    // Fixed scan rate
    assign scan_hit  = &count[SCAN_SHIFT-1:0];

    // Registered pulses, one cycle wide
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step      <= 1'b0;
            scan_step <= 1'b0;
        end else begin
            step      <= step_hit;
            scan_step <= scan_hit;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bcd_digit_counter.sv
`timescale 1ns/1ns
`default_nettype none

module bcd_digit_counter import lab_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               step,
    input  logic               up,
    output logic [DIGIT_W-1:0] value
);

    logic [DIGIT_W-1:0] next_value;

    //////////////////////////////
    // Next digit
    //////////////////////////////

    always_comb begin
        if (up) begin
            // 9 wraps to 0
            // Anything above 9 also falls back to 0
            if (value >= DIGIT_MAX) begin
                next_value = '0;
            end else begin
                next_value = value + 1'b1;
            end
        end else begin
            // 0 wraps to 9
            if (value == '0) begin
                next_value = DIGIT_MAX;
            end else if (value > DIGIT_MAX) begin
                next_value = DIGIT_MAX;
            end else begin
                next_value = value - 1'b1;
            end
        end
    end

    // Digit register, moves only on step
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            value <= '0;
        end else if (step) begin
            value <= next_value;
        end
    end

endmodule

`default_nettype wire

//--- rtl/digit_alu.sv
`timescale 1ns/1ns
`default_nettype none

module digit_alu import lab_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  digits_t             digits,
    input  alu_op_e             op,
    output logic [RESULT_W-1:0] result
);

    // Operands widened to the result width
    logic [RESULT_W-1:0] ones_ext;
    logic [RESULT_W-1:0] tens_ext;
    // Unregistered result
    logic [RESULT_W-1:0] alu_val;

    assign ones_ext = RESULT_W'(digits.ones);
    assign tens_ext = RESULT_W'(digits.tens);

    //////////////////////////////
    // Operation select
    //////////////////////////////

    always_comb begin
        case (op)
            ALU_ADD: begin
                // At most 18
                alu_val = ones_ext + tens_ext;
            end
            ALU_SUB: begin
                // Two's complement wrap when tens > ones
                alu_val = ones_ext - tens_ext;
            end
            ALU_MUL: begin
                // 9 * 9 = 81, fits
                alu_val = ones_ext * tens_ext;
            end
            ALU_CAT: begin
                // Digits read as a two-digit BCD number
                alu_val = {digits.tens, digits.ones};
            end
            default: begin
                alu_val = '0;
            end
        endcase
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    // One cycle behind digits and op
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else begin
            result <= alu_val;
        end
    end

endmodule

`default_nettype wire

//--- rtl/scan_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module scan_sequencer import lab_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                scan_step,
    input  logic [RESULT_W-1:0] result,
    input  alu_op_e             op,
    output logic [AN_W-1:0]     an,
    output logic [SEG_W-1:0]    seg
);

    scan_state_e state;
    scan_state_e state_next;

    // Glyph per active digit, indexed like the anodes
    logic [SEG_W-1:0] glyph [NUM_SCAN];
    // Anodes of the active digits only
    logic [NUM_SCAN-1:0] an_act;

    //////////////////////////////
    // State register
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= SCAN_LOW;
        end else begin
            state <= state_next;
        end
    end

    // Rotation low, high, op, low
    always_comb begin
        state_next = state;
        if (scan_step) begin
            case (state)
                SCAN_LOW: begin
                    state_next = SCAN_HIGH;
                end
                SCAN_HIGH: begin
                    state_next = SCAN_OP;
                end
                SCAN_OP: begin
                    state_next = SCAN_LOW;
                end
                default: begin
                    // Unused code, back to start
                    state_next = SCAN_LOW;
                end
            endcase
        end
    end

    //////////////////////////////
    // Glyph lookup
    //////////////////////////////

    // Result nibbles as hex 0 to F
    assign glyph[0] = HEX_GLYPH[result[3:0]];
    assign glyph[1] = HEX_GLYPH[result[7:4]];
    // Opcode letter, stands in for a control decoder
    assign glyph[2] = OP_GLYPH[op];

    //////////////////////////////
    // Anode and segment drive
    //////////////////////////////

    // Pure decode of the state, no extra register
    always_comb begin
        an_act = '1;
        seg    = glyph[0];
        case (state)
            SCAN_LOW: begin
                an_act[0] = 1'b0;
                seg       = glyph[0];
            end
            SCAN_HIGH: begin
                an_act[1] = 1'b0;
                seg       = glyph[1];
            end
            SCAN_OP: begin
                an_act[2] = 1'b0;
                seg       = glyph[2];
            end
            default: begin
                an_act[0] = 1'b0;
                seg       = glyph[0];
            end
        endcase
    end

    // Unused digits stay dark
    assign an[NUM_SCAN-1:0]    = an_act;
    assign an[AN_W-1:NUM_SCAN] = '1;

endmodule

`default_nettype wire

//--- rtl/counter_alu_top.sv
`timescale 1ns/1ns
`default_nettype none

module counter_alu_top import lab_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [SW_W-1:0]     sw,
    output logic [RESULT_W-1:0] led,
    output logic [AN_W-1:0]     an,
    output logic [SEG_W-1:0]    seg
);

    // Switch fields
    ctrl_t ctrl;

    // Timer pulses
    logic step;
    logic scan_step;

    // Counter outputs
    logic [DIGIT_W-1:0] ones_val;
    logic [DIGIT_W-1:0] tens_val;
    digits_t            digits;

    logic [RESULT_W-1:0] result;

    // Switches are plain levels
    assign ctrl = ctrl_t'(sw);

    //////////////////////////////
    // Timing
    //////////////////////////////

    rate_timer timer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rate_sel  (ctrl.rate_sel),
        .step      (step),
        .scan_step (scan_step)
    );

    //////////////////////////////
    // Digits
    //////////////////////////////

    // Each digit keeps its own direction
    bcd_digit_counter ones_i (
        .clk    (clk),
        .arst_n (arst_n),
        .step   (step),
        .up     (ctrl.dir_ones),
        .value  (ones_val)
    );

    bcd_digit_counter tens_i (
        .clk    (clk),
        .arst_n (arst_n),
        .step   (step),
        .up     (ctrl.dir_tens),
        .value  (tens_val)
    );

    assign digits.tens = tens_val;
    assign digits.ones = ones_val;

    //////////////////////////////
    // ALU and display
    //////////////////////////////

    digit_alu alu_i (
        .clk    (clk),
        .arst_n (arst_n),
        .digits (digits),
        .op     (ctrl.op),
        .result (result)
    );

    scan_sequencer scan_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .scan_step (scan_step),
        .result    (result),
        .op        (ctrl.op),
        .an        (an),
        .seg       (seg)
    );

    // LEDs show the raw result
    assign led = result;

endmodule

`default_nettype wire

//--- dv/counter_alu_properties.sv
`timescale 1ns/1ns
`default_nettype none

module counter_alu_properties import lab_pkg::*; (
    input logic                clk,
    input logic                arst_n,
    input logic [AN_W-1:0]     an,
    input logic [RESULT_W-1:0] result,
    input alu_op_e             op
);

    //////////////////////////////
    // Anodes
    //////////////////////////////

    // Exactly one active digit lit
    one_digit_lit: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot(~an[NUM_SCAN-1:0]))
        else $error("active anodes not one-hot: %h", an);

    // Unused digits dark
    unused_dark: assert property (@(posedge clk) disable iff (!arst_n)
        an[AN_W-1:NUM_SCAN] == '1)
        else $error("unused anode driven: %h", an);

    //////////////////////////////
    // Result
    //////////////////////////////

    // CAT shows two BCD digits, once the registered result has caught up with op
    cat_is_bcd: assert property (@(posedge clk) disable iff (!arst_n)
        (op == ALU_CAT) && $past(op == ALU_CAT)
            |-> (result[7:4] <= 4'd9) && (result[3:0] <= 4'd9))
        else $error("CAT result not BCD: %h", result);

endmodule

// Sequencer sees both the anodes and the ALU result
bind scan_sequencer counter_alu_properties props_i (
    .clk    (clk),
    .arst_n (arst_n),
    .an     (an),
    .result (result),
    .op     (op)
);

`default_nettype wire

//--- dv/tb_counter_alu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_counter_alu import lab_pkg::*; ();

    localparam int          CLK_HALF   = 4;
    localparam int          RST_CYCLES = 16;
    localparam int          DRIVE_DLY  = 1;
    localparam int          WAIT_LIMIT = 4000;
    localparam logic [31:0] SEED       = 32'h655f_d8ce;

    // Active low with g in bit 6
    localparam logic [SEG_W-1:0] SEG_HEX [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };
    // Letters A, S, M, C
    localparam logic [SEG_W-1:0] SEG_OP [4] = '{7'h08, 7'h12, 7'h48, 7'h46};

    logic                clk;
    logic                arst_n;
    ctrl_t               ctrl;
    logic [RESULT_W-1:0] led;
    logic [AN_W-1:0]     an;
    logic [SEG_W-1:0]    seg;

    // Model state
    logic [TIMER_W-1:0]  m_count;
    logic                m_step;
    logic                m_scan;
    digits_t             m_digits;
    logic [RESULT_W-1:0] m_result;
    scan_state_e         m_state;

    int errors;
    int checks;
    int cycle;
    int last_step;
    bit timed_out;

    counter_alu_top dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .sw     (ctrl),
        .led    (led),
        .an     (an),
        .seg    (seg)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    //////////////////////////////
    // Reference functions
    //////////////////////////////

    function automatic logic [DIGIT_W-1:0] next_digit(logic [DIGIT_W-1:0] d, logic up);
        if (up) begin
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        end
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    function automatic logic [RESULT_W-1:0] ref_result(digits_t d, alu_op_e op);
        logic [RESULT_W-1:0] o;
        logic [RESULT_W-1:0] t;
        o = {4'd0, d.ones};
        t = {4'd0, d.tens};
        case (op)
            ALU_ADD: return o + t;
            // Wraps below zero
            ALU_SUB: return o - t;
            ALU_MUL: return o * t;
            default: return {d.tens, d.ones};
        endcase
    endfunction

    // Digit k lit means an[k] low
    function automatic logic [AN_W-1:0] ref_an(scan_state_e st);
        case (st)
            SCAN_LOW:  return 8'hFE;
            SCAN_HIGH: return 8'hFD;
            default:   return 8'hFB;
        endcase
    endfunction

    function automatic logic [SEG_W-1:0] ref_seg(scan_state_e st, logic [RESULT_W-1:0] res,
                                                  alu_op_e op);
        case (st)
            SCAN_LOW:  return SEG_HEX[res[3:0]];
            SCAN_HIGH: return SEG_HEX[res[7:4]];
            default:   return SEG_OP[op];
        endcase
    endfunction

    //////////////////////////////
    // Checks and waits
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        errors++;
        $display("Timed out waiting for %s", what);
    endtask

    task automatic drive(input logic tens_up, input logic ones_up, input alu_op_e op,
                         input logic [SEL_W-1:0] rate);
        @(posedge clk);
        #DRIVE_DLY;
        ctrl.dir_tens = tens_up;
        ctrl.dir_ones = ones_up;
        ctrl.op       = op;
        ctrl.rate_sel = rate;
    endtask

    // Masked led compare
    task automatic wait_led(input logic [7:0] value, input logic [7:0] mask, input string what);
        int n;
        n = 0;
        while (!timed_out && (led & mask) !== value) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) report_timeout(what);
        end
    endtask

    task automatic wait_change(output int at);
        logic [7:0] last;
        int         n;
        last = led;
        n    = 0;
        @(negedge clk);
        while (!timed_out && led === last) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) report_timeout("led change");
        end
        at = cycle;
    endtask

    //////////////////////////////
    // Model and compare
    //////////////////////////////

    // Old values in, new values out, once per edge
    always @(posedge clk) begin
        logic [TIMER_W-1:0] mask;
        cycle = cycle + 1;
        if (!arst_n) begin
            m_count  = '0;
            m_step   = 1'b0;
            m_scan   = 1'b0;
            m_digits = '0;
            m_result = '0;
            m_state  = SCAN_LOW;
        end else begin
            mask     = (TIMER_W'(1) << ctrl.rate_sel) - 1'b1;
            m_result = ref_result(m_digits, ctrl.op);
            if (m_scan) begin
                m_state = (m_state == SCAN_LOW)  ? SCAN_HIGH :
                          (m_state == SCAN_HIGH) ? SCAN_OP : SCAN_LOW;
            end
            if (m_step) begin
                m_digits.ones = next_digit(m_digits.ones, ctrl.dir_ones);
                m_digits.tens = next_digit(m_digits.tens, ctrl.dir_tens);
            end
            m_step = ((m_count & mask) == mask);
            if (m_step) last_step = cycle;
            m_scan  = (m_count[SCAN_SHIFT-1:0] == '1);
            m_count = m_count + 1'b1;
        end
    end

    // Mid-cycle compare with all outputs settled
    always @(negedge clk) begin
        if (cycle > 0) begin
            check_value("led", 32'(led), 32'(m_result));
            check_value("an", 32'(an), 32'(ref_an(m_state)));
            check_value("seg", 32'(seg), 32'(ref_seg(m_state, m_result, ctrl.op)));
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        logic [31:0] seed_ret;
        int          t1;
        int          t2;
        int          idx0;
        int          n;
        errors    = 0;
        checks    = 0;
        cycle     = 0;
        last_step = 0;
        timed_out = 1'b0;
        seed_ret  = $urandom(SEED);
        // Frozen count until released
        ctrl.dir_tens = 1'b1;
        ctrl.dir_ones = 1'b1;
        ctrl.op       = ALU_CAT;
        ctrl.rate_sel = 5'd31;
        arst_n        = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY arst_n = 1'b1;

        // Reset values
        @(negedge clk);
        check_value("led", 32'(led), 32'h00);
        check_value("an", 32'(an), 32'hFE);
        check_value("seg", 32'(seg), 32'(SEG_HEX[0]));

        // Both digits up at full rate, then wrap to 00
        drive(1'b1, 1'b1, ALU_CAT, 5'd0);
        wait_led(8'h99, 8'hFF, "led 99");
        wait_led(8'h00, 8'hFF, "led 00 after wrap");

        // Ones down, tens up, random slow rates
        for (int k = 0; k < 3; k++) begin
            drive(1'b1, 1'b0, ALU_CAT, 5'($urandom % 3));
            wait_led(8'h09, 8'h0F, "ones at 9");
            wait_led(8'h08, 8'h0F, "ones at 8");
        end

        // Step period and step to led latency
        for (int s = 2; s < 4; s++) begin
            drive(1'b1, 1'b1, ALU_CAT, 5'(s));
            // Steps from the old rate drain first
            repeat (2) @(negedge clk);
            wait_change(t1);
            wait_change(t1);
            check_value("step latency", 32'(t1 - last_step), 32'd2);
            wait_change(t2);
            check_value("step period", 32'(t2 - t1), 32'(1 << s));
        end

        // Single steps until tens > ones for a negative difference
        drive(1'b0, 1'b1, ALU_ADD, 5'd31);
        repeat (3) @(negedge clk);
        n = 0;
        while (!timed_out && m_digits.tens <= m_digits.ones) begin
            drive(1'b0, 1'b1, ALU_ADD, 5'd0);
            drive(1'b0, 1'b1, ALU_ADD, 5'd31);
            repeat (3) @(negedge clk);
            n++;
            if (n > 20) report_timeout("tens above ones");
        end

        // Each opcode checked one registered cycle after the change
        for (int k = 0; k < 4; k++) begin
            drive(1'b0, 1'b1, alu_op_e'(k), 5'd31);
            repeat (2) @(negedge clk);
            check_value("led", 32'(led), 32'(ref_result(m_digits, alu_op_e'(k))));
            if (alu_op_e'(k) == ALU_SUB) check_value("led[7]", 32'(led[7]), 32'd1);
        end

        // Scan rotation with 16 cycles per digit
        n = 0;
        @(negedge clk);
        t1 = 32'(an);
        while (!timed_out && 32'(an) == t1) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) report_timeout("anode change");
        end
        idx0 = !an[0] ? 0 : (!an[1] ? 1 : 2);
        for (int i = 0; i < 48; i++) begin
            t2 = (idx0 + i / 16) % 3;
            check_value("an", 32'(an), 32'(ref_an(scan_state_e'(t2))));
            check_value("seg", 32'(seg), 32'(ref_seg(scan_state_e'(t2), m_result, ctrl.op)));
            @(negedge clk);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
rtl/lab_pkg.sv
rtl/rate_timer.sv
rtl/bcd_digit_counter.sv
rtl/digit_alu.sv
rtl/scan_sequencer.sv
rtl/counter_alu_top.sv
dv/counter_alu_properties.sv
dv/tb_counter_alu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the counter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_counter_alu -f all.f \
    -o sim_counter_alu > build.log 2>&1 \
    || { cat build.log; echo "Build failed, see build.log"; exit 1; }

# A crash or a failed assertion also counts as a failing run
./obj_dir/sim_counter_alu > sim.log 2>&1 || echo "Checks failed" >> sim.log
cat sim.log

grep -q "Checks failed" sim.log && exit 1 || exit 0
